// File: Bender.yml
package:
  name: tx_baseband

sources:
  - tx_timing_pkg.sv
  - tx_frame_pkg.sv
  - tx_frame_ctrl.sv
  - tx_sample_gen.sv
  - tx_iq_fifo.sv
  - tx_on_detection.sv
  - tx_top.sv
  - target: simulation
    files:
      - tx_top_properties.sv
      - tb_tx_top.sv

// File: src.f
tx_timing_pkg.sv
tx_frame_pkg.sv
tx_frame_ctrl.sv
tx_sample_gen.sv
tx_iq_fifo.sv
tx_on_detection.sv
tx_top.sv
tx_top_properties.sv
tb_tx_top.sv

// File: tb_tx_top.sv
// testbench for tx_top: clock, reset, LFSR stimulus, IQ reference, compare and timing monitor
`timescale 1ns/1ps

module tb_tx_top;

    localparam int n_frames = 12;

    logic                              clk;
    logic                              rstn;
    logic                              tx_req;
    logic [tx_frame_pkg::len_w-1:0]    tx_len;
    logic [tx_frame_pkg::seed_w-1:0]   tx_seed;
    logic [tx_timing_pkg::delay_w-1:0] bb_rf_delay;
    logic [tx_timing_pkg::ext_w-1:0]   rf_end_ext;
    logic [tx_timing_pkg::ext_w-1:0]   chain_on_delay;
    logic [tx_timing_pkg::ext_w-1:0]   chain_off_delay;
    logic                              dac_rd;
    logic                              tx_busy;
    logic [tx_frame_pkg::sample_w-1:0] dac_data;
    logic                              fifo_empty;
    logic                              tx_core_is_ongoing;
    logic                              tx_bb_is_ongoing;
    logic                              tx_rf_is_ongoing;
    logic                              tx_chain_on;
    logic                              pulse_tx_bb_end;

    logic [15:0] lfsr = 16'd14;
    logic [tx_frame_pkg::sample_w-1:0] exp_q [$];
    int cyc = 0;
    int cycle_limit = 100;
    int stall_left = 0;
    // delay fields of the current frame in delay units
    int d;
    int e;
    int con;
    int coff;
    int bb_rise = 0;
    int bb_end = 0;
    logic bb_q = 1'b0;
    logic rf_q = 1'b0;
    logic ch_q = 1'b0;

    tx_top UUT (
        .clk, .rstn, .tx_req, .tx_len, .tx_seed, .bb_rf_delay, .rf_end_ext, .chain_on_delay,
        .chain_off_delay, .dac_rd, .tx_busy, .dac_data, .fifo_empty, .tx_core_is_ongoing,
        .tx_bb_is_ongoing, .tx_rf_is_ongoing, .tx_chain_on, .pulse_tx_bb_end
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic int lfsr_bits(int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // expected word k of a frame has I = seed + k mod 2^16 and Q = ~I
    function automatic logic [tx_frame_pkg::sample_w-1:0] iq_word(int seed, int k);
        int s;
        s = (seed + k) % 65536;
        return {s[15:0], ~s[15:0]};
    endfunction

    // measured delays within two cycles of the target count as on target
    function automatic int snap_to(int meas, int target);
        if (meas >= target - 2 && meas <= target + 2) begin
            return target;
        end
        return meas;
    endfunction

    task automatic compare_values(string name, longint actual, longint expected);
        if (actual != expected) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // every input change happens on the falling edge with a fresh dac_rd draw
    task automatic next_cycle();
        @(negedge clk);
        if (stall_left > 0) begin
            dac_rd     = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            dac_rd = |lfsr_bits(2);
        end
    endtask

    task automatic check_idle();
        compare_values("tx_busy", tx_busy, 0);
        compare_values("fifo_empty", fifo_empty, 1);
        compare_values("tx_core_is_ongoing", tx_core_is_ongoing, 0);
        compare_values("tx_bb_is_ongoing", tx_bb_is_ongoing, 0);
        compare_values("tx_rf_is_ongoing", tx_rf_is_ongoing, 0);
        compare_values("tx_chain_on", tx_chain_on, 0);
        compare_values("pulse_tx_bb_end", pulse_tx_bb_end, 0);
    endtask

    task automatic run_frame();
        int len;
        int seed;
        len  = 1 + lfsr_bits(6) % 40;
        seed = lfsr_bits(16);
        d    = 1 + lfsr_bits(3) % 6;
        e    = 1 + lfsr_bits(3) % 6;
        con  = 1 + lfsr_bits(3) % 6;
        coff = 1 + lfsr_bits(3) % 6;
        // chain delays past the rf off point would never be reached by the counter
        if (con > d + e) begin
            con = d + e;
        end
        if (coff > d + e) begin
            coff = d + e;
        end
        bb_rf_delay     = d[tx_timing_pkg::delay_w-1:0];
        rf_end_ext      = e[tx_timing_pkg::ext_w-1:0];
        chain_on_delay  = con[tx_timing_pkg::ext_w-1:0];
        chain_off_delay = coff[tx_timing_pkg::ext_w-1:0];
        cycle_limit     = cycle_limit + len * 4 + (d + e) * 4 + 96;
        // let the scaled delay registers settle
        repeat (3) next_cycle();
        tx_len  = len[tx_frame_pkg::len_w-1:0];
        tx_seed = seed[tx_frame_pkg::seed_w-1:0];
        tx_req  = 1'b1;
        // about half the frames open with a long DAC stall to exhaust the credits
        if (lfsr_bits(1) == 1) begin
            stall_left = 16 + lfsr_bits(4);
        end
        next_cycle();
        compare_values("tx_busy", tx_busy, 1);
        compare_values("tx_core_is_ongoing", tx_core_is_ongoing, 1);
        for (int k = 0; k < len; k++) begin
            exp_q.push_back(iq_word(seed, k));
        end
        // a request held while busy must not start a second frame
        tx_len = ~tx_len;
        next_cycle();
        tx_req = 1'b0;
        while (tx_busy || !fifo_empty || tx_bb_is_ongoing || tx_rf_is_ongoing || tx_chain_on) begin
            next_cycle();
        end
        compare_values("words left in frame", exp_q.size(), 0);
        next_cycle();
        check_idle();
    endtask

    // compare process and activity monitor sample on the rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rstn) begin
            if (UUT.u_props.fail_count != 0) begin
                abort_run("a bound assertion on tx_top failed");
            end
            compare_values("tx_core_is_ongoing", tx_core_is_ongoing, tx_busy);
            // more unread words than the FIFO holds means the generator is still pushing
            if (exp_q.size() > tx_frame_pkg::fifo_depth) begin
                compare_values("tx_busy", tx_busy, 1);
            end
            if (dac_rd && !fifo_empty) begin
                if (exp_q.size() == 0) begin
                    abort_run("the DAC read a word that no frame request produced");
                end else begin
                    compare_values("dac_data", dac_data, exp_q.pop_front());
                end
            end
            if (tx_bb_is_ongoing && !bb_q) begin
                bb_rise = cyc;
            end
            if (pulse_tx_bb_end) begin
                bb_end = cyc;
                // a long enough window must have turned rf and the chain on
                if (cyc - bb_rise >= d * 4 + 4) begin
                    compare_values("tx_rf_is_ongoing", tx_rf_is_ongoing, 1);
                end
                if (cyc - bb_rise >= con * 4 + 4) begin
                    compare_values("tx_chain_on", tx_chain_on, 1);
                end
            end
            if (tx_rf_is_ongoing && !rf_q) begin
                compare_values("tx_rf_is_ongoing rise delay",
                               snap_to(cyc - bb_rise, d * 4), d * 4);
            end
            if (!tx_rf_is_ongoing && rf_q) begin
                compare_values("tx_rf_is_ongoing fall delay",
                               snap_to(cyc - bb_end, (d + e) * 4), (d + e) * 4);
            end
            if (tx_chain_on && !ch_q) begin
                compare_values("tx_chain_on rise delay", snap_to(cyc - bb_rise, con * 4), con * 4);
            end
            if (!tx_chain_on && ch_q) begin
                compare_values("tx_chain_on fall delay", snap_to(cyc - bb_end, coff * 4), coff * 4);
            end
            bb_q = tx_bb_is_ongoing;
            rf_q = tx_rf_is_ongoing;
            ch_q = tx_chain_on;
        end
    end

    initial begin
        while (cyc <= cycle_limit) begin
            @(posedge clk);
        end
        abort_run("timeout: the frames did not finish within the cycle budget");
    end

    initial begin
        rstn            = 1'b0;
        tx_req          = 1'b0;
        tx_len          = '0;
        tx_seed         = '0;
        bb_rf_delay     = 1;
        rf_end_ext      = 1;
        chain_on_delay  = 1;
        chain_off_delay = 1;
        dac_rd          = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        next_cycle();
        check_idle();
        for (int f = 0; f < n_frames; f++) begin
            run_frame();
        end
        if (UUT.u_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tx_frame_ctrl.sv
// tx frame controller: host request decode and phy start/started/done sequencing
`timescale 1ns/1ps

module tx_frame_ctrl (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            tx_req,
    input  logic [tx_frame_pkg::len_w-1:0]  tx_len,
    input  logic [tx_frame_pkg::seed_w-1:0] tx_seed,
    input  logic                            gen_last,
    output logic                            tx_busy,
    output logic                            phy_tx_start,
    output logic                            phy_tx_started,
    output logic                            phy_tx_done,
    output logic                            gen_go,
    output logic [tx_frame_pkg::len_w-1:0]  gen_len,
    output logic [tx_frame_pkg::seed_w-1:0] gen_seed
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_STARTED,
        S_RUN,
        S_DONE
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    // a request is only taken here, so tx_busy masks the rest
                    if (tx_req) begin
                        state <= S_START;
                    end
                end
                S_START:   state <= S_STARTED;
                S_STARTED: state <= S_RUN;
                S_RUN: begin
                    if (gen_last) begin
                        state <= S_DONE;
                    end
                end
                S_DONE:    state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // frame parameters, held for the generator until the next request
    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_req) begin
            gen_len  <= tx_len;
            gen_seed <= tx_seed;
        end
    end

    // moore strobes, each state lasts one cycle except idle and run
    assign phy_tx_start   = (state == S_START);
    assign phy_tx_started = (state == S_STARTED);
    assign gen_go         = (state == S_STARTED);
    assign phy_tx_done    = (state == S_DONE);
    assign tx_busy        = (state != S_IDLE);

endmodule

// File: tx_frame_pkg.sv
// frame constants: IQ word layout, frame length, FIFO depth and credit width
package tx_frame_pkg;

    // one I or Q half of a sample, also the width of the host seed
    localparam int unsigned seed_w = 16;

    // IQ word, I in the high half and Q in the low half
    localparam int unsigned sample_w = 2 * seed_w;

    // frame length in samples
    localparam int unsigned len_w = 10;

    // transmit FIFO
    localparam int unsigned fifo_depth = 8;
    localparam int unsigned ptr_w = $clog2(fifo_depth);

    // credits and FIFO occupancy both count up to fifo_depth
    localparam int unsigned credit_w = 4;
    localparam logic [credit_w-1:0] credit_init = credit_w'(fifo_depth);

endpackage

// File: tx_iq_fifo.sv
// transmit IQ FIFO, first-word-fall-through, one credit returned per read
`timescale 1ns/1ps

module tx_iq_fifo (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              push,
    input  logic [tx_frame_pkg::sample_w-1:0] push_data,
    input  logic                              dac_rd,
    output logic [tx_frame_pkg::sample_w-1:0] dac_data,
    output logic                              fifo_empty,
    output logic                              credit_ret
);

    logic [tx_frame_pkg::sample_w-1:0] mem [tx_frame_pkg::fifo_depth];
    logic [tx_frame_pkg::ptr_w-1:0]    wr_ptr;
    logic [tx_frame_pkg::ptr_w-1:0]    rd_ptr;
    logic [tx_frame_pkg::credit_w-1:0] count;
    logic                              rd;

    assign fifo_empty = (count == '0);
    assign rd         = dac_rd && !fifo_empty;
    assign dac_data   = mem[rd_ptr];

    // no full check, the generator's credits bound the occupancy
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_ret <= rd;
        end
    end

endmodule

// File: tx_on_detection.sv
// tx activity detector: baseband, core, rf and tx chain windows from FIFO and phy strobes
`timescale 1ns/1ps

module tx_on_detection (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [tx_timing_pkg::delay_w-1:0]  bb_rf_delay_count_top,
    input  logic [tx_timing_pkg::ext_w-1:0]    rf_end_ext_count_top,
    input  logic [tx_timing_pkg::ext_w-1:0]    bb_start_tx_chain_on_delay_count_top,
    input  logic [tx_timing_pkg::ext_w-1:0]    bb_end_tx_chain_off_delay_count_top,
    input  logic                               phy_tx_start,
    input  logic                               phy_tx_started,
    input  logic                               phy_tx_done,
    input  logic                               tx_iq_fifo_empty,
    output logic                               tx_core_is_ongoing,
    output logic                               tx_bb_is_ongoing,
    output logic                               tx_rf_is_ongoing,
    output logic                               tx_chain_on,
    output logic                               pulse_tx_bb_end
);

    logic                            bb_ongoing_int;
    logic [3:0]                      bb_hist;
    logic                            search_start;
    logic                            fifo_empty_q;
    logic                            iq_running;
    logic                            core_ongoing_q;
    logic                            pulse_tx_bb_start;
    logic [tx_timing_pkg::cnt_w-1:0] delay_cnt;
    logic [tx_timing_pkg::cnt_w-1:0] rf_on_scale;
    logic [tx_timing_pkg::cnt_w-1:0] rf_off_scale;
    logic [tx_timing_pkg::cnt_w-1:0] rf_off_scale_p1;
    logic [tx_timing_pkg::cnt_w-1:0] chain_on_scale;
    logic [tx_timing_pkg::cnt_w-1:0] chain_off_scale;

    assign tx_core_is_ongoing = core_ongoing_q | phy_tx_start;

    // four extra cycles so the end pulse sits inside the busy window
    assign tx_bb_is_ongoing  = bb_ongoing_int | (|bb_hist);
    assign pulse_tx_bb_start = bb_ongoing_int & ~bb_hist[0];
    assign pulse_tx_bb_end   = ~bb_ongoing_int & bb_hist[0];

    // delay fields scaled to clock cycles, one register stage behind the inputs
    always_ff @(posedge clk) begin
        rf_on_scale     <= bb_rf_delay_count_top * tx_timing_pkg::count_scale;
        rf_off_scale    <= rf_on_scale + rf_end_ext_count_top * tx_timing_pkg::count_scale;
        rf_off_scale_p1 <= rf_off_scale + 1'b1;
        chain_on_scale  <= bb_start_tx_chain_on_delay_count_top * tx_timing_pkg::count_scale;
        chain_off_scale <= bb_end_tx_chain_off_delay_count_top * tx_timing_pkg::count_scale;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bb_ongoing_int <= 1'b0;
            bb_hist        <= '0;
            search_start   <= 1'b0;
            fifo_empty_q   <= 1'b1;
            iq_running     <= 1'b0;
            core_ongoing_q <= 1'b0;
        end else begin
            bb_hist      <= {bb_hist[2:0], bb_ongoing_int};
            fifo_empty_q <= tx_iq_fifo_empty;

            if (phy_tx_start) begin
                core_ongoing_q <= 1'b1;
            end else if (phy_tx_done) begin
                core_ongoing_q <= 1'b0;
            end

            // look for empty to non-empty after started, the reverse after done
            if (phy_tx_started) begin
                search_start <= 1'b1;
            end else if (phy_tx_done) begin
                search_start <= 1'b0;
            end

            if (search_start && fifo_empty_q && !tx_iq_fifo_empty) begin
                bb_ongoing_int <= 1'b1;
            end else if (!search_start && !fifo_empty_q && tx_iq_fifo_empty) begin
                bb_ongoing_int <= 1'b0;
            end

            if (pulse_tx_bb_start) begin
                iq_running <= 1'b1;
            end else if (pulse_tx_bb_end) begin
                iq_running <= 1'b0;
            end
        end
    end

    // one counter serves both edges, restarted on each and parked past the rf off point
    always_ff @(posedge clk) begin
        if (!rstn) begin
            delay_cnt        <= '0;
            tx_rf_is_ongoing <= 1'b0;
            tx_chain_on      <= 1'b0;
        end else if (pulse_tx_bb_start || pulse_tx_bb_end) begin
            delay_cnt <= '0;
        end else begin
            if (delay_cnt != rf_off_scale_p1) begin
                delay_cnt <= delay_cnt + 1'b1;
            end

            if (iq_running && delay_cnt == rf_on_scale) begin
                tx_rf_is_ongoing <= 1'b1;
            end else if (!iq_running && delay_cnt == rf_off_scale) begin
                tx_rf_is_ongoing <= 1'b0;
            end

            if (iq_running && delay_cnt == chain_on_scale) begin
                tx_chain_on <= 1'b1;
            end else if (!iq_running && delay_cnt == chain_off_scale) begin
                tx_chain_on <= 1'b0;
            end
        end
    end

endmodule

// File: tx_sample_gen.sv
// IQ sample generator with credit-based flow control towards the tx FIFO
`timescale 1ns/1ps

module tx_sample_gen (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              gen_go,
    input  logic [tx_frame_pkg::len_w-1:0]    gen_len,
    input  logic [tx_frame_pkg::seed_w-1:0]   gen_seed,
    input  logic                              credit_ret,
    output logic                              push,
    output logic [tx_frame_pkg::sample_w-1:0] push_data,
    output logic                              gen_last
);

    logic                              active;
    logic [tx_frame_pkg::len_w-1:0]    idx;
    logic [tx_frame_pkg::credit_w-1:0] credit_cnt;
    logic [tx_frame_pkg::seed_w-1:0]   i_word;

    // sample rule: I = seed + k, Q = ~I
    assign i_word    = gen_seed + {{(tx_frame_pkg::seed_w - tx_frame_pkg::len_w){1'b0}}, idx};
    assign push_data = {i_word, ~i_word};

    // one push per cycle while a credit is held, otherwise stall in place
    assign push     = active && (credit_cnt != '0);
    assign gen_last = push && (idx == gen_len - 1'b1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (gen_go) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (push) begin
            if (gen_last) begin
                active <= 1'b0;
            end
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= tx_frame_pkg::credit_init;
        end else begin
            case ({credit_ret, push})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                // a return and a push in the same cycle cancel
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// File: tx_timing_pkg.sv
// timing constants for the tx activity detector: count scale and delay field widths
package tx_timing_pkg;

    // width of the bb to rf delay field
    localparam int unsigned delay_w = 8;

    // width of the rf extension and tx chain on/off fields
    localparam int unsigned ext_w = 7;

    // scaled delay counter, wide enough for (255 + 127) * count_scale
    localparam int unsigned cnt_w = 14;

    // clock cycles per delay unit
    // kept at counter width so a field times the scale stays in counter range
    localparam logic [cnt_w-1:0] count_scale = 4;

endpackage

// File: tx_top.sv
// baseband transmit top: frame controller, sample generator, IQ FIFO and activity detector
`timescale 1ns/1ps

module tx_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              tx_req,
    input  logic [tx_frame_pkg::len_w-1:0]    tx_len,
    input  logic [tx_frame_pkg::seed_w-1:0]   tx_seed,
    input  logic [tx_timing_pkg::delay_w-1:0] bb_rf_delay,
    input  logic [tx_timing_pkg::ext_w-1:0]   rf_end_ext,
    input  logic [tx_timing_pkg::ext_w-1:0]   chain_on_delay,
    input  logic [tx_timing_pkg::ext_w-1:0]   chain_off_delay,
    input  logic                              dac_rd,
    output logic                              tx_busy,
    output logic [tx_frame_pkg::sample_w-1:0] dac_data,
    output logic                              fifo_empty,
    output logic                              tx_core_is_ongoing,
    output logic                              tx_bb_is_ongoing,
    output logic                              tx_rf_is_ongoing,
    output logic                              tx_chain_on,
    output logic                              pulse_tx_bb_end
);

    logic                              phy_tx_start;
    logic                              phy_tx_started;
    logic                              phy_tx_done;
    logic                              gen_go;
    logic [tx_frame_pkg::len_w-1:0]    gen_len;
    logic [tx_frame_pkg::seed_w-1:0]   gen_seed;
    logic                              gen_last;
    logic                              push;
    logic [tx_frame_pkg::sample_w-1:0] push_data;
    logic                              credit_ret;

    tx_frame_ctrl u_ctrl (
        .clk, .rstn, .tx_req, .tx_len, .tx_seed, .gen_last, .tx_busy,
        .phy_tx_start, .phy_tx_started, .phy_tx_done, .gen_go, .gen_len, .gen_seed
    );

    tx_sample_gen u_gen (
        .clk, .rstn, .gen_go, .gen_len, .gen_seed, .credit_ret, .push, .push_data, .gen_last
    );

    tx_iq_fifo u_fifo (
        .clk, .rstn, .push, .push_data, .dac_rd, .dac_data, .fifo_empty, .credit_ret
    );

    tx_on_detection u_det (
        .clk                                  (clk),
        .rstn                                 (rstn),
        .bb_rf_delay_count_top                (bb_rf_delay),
        .rf_end_ext_count_top                 (rf_end_ext),
        .bb_start_tx_chain_on_delay_count_top (chain_on_delay),
        .bb_end_tx_chain_off_delay_count_top  (chain_off_delay),
        .phy_tx_start                         (phy_tx_start),
        .phy_tx_started                       (phy_tx_started),
        .phy_tx_done                          (phy_tx_done),
        .tx_iq_fifo_empty                     (fifo_empty),
        .tx_core_is_ongoing                   (tx_core_is_ongoing),
        .tx_bb_is_ongoing                     (tx_bb_is_ongoing),
        .tx_rf_is_ongoing                     (tx_rf_is_ongoing),
        .tx_chain_on                          (tx_chain_on),
        .pulse_tx_bb_end                      (pulse_tx_bb_end)
    );

endmodule

// File: tx_top_properties.sv
// concurrent assertions on phy strobes, generator credits and the bb end pulse, bound to tx_top
`timescale 1ns/1ps

module tx_top_properties (
    input logic                              clk,
    input logic                              rstn,
    input logic                              phy_tx_start,
    input logic                              phy_tx_done,
    input logic [tx_frame_pkg::credit_w-1:0] credit_cnt,
    input logic                              pulse_tx_bb_end,
    input logic                              tx_bb_is_ongoing
);

    int fail_count = 0;

    start_is_pulse: assert property (@(posedge clk) disable iff (!rstn)
        phy_tx_start |=> !phy_tx_start)
    else begin
        $error("phy_tx_start held longer than one cycle");
        fail_count++;
    end

    done_is_pulse: assert property (@(posedge clk) disable iff (!rstn)
        phy_tx_done |=> !phy_tx_done)
    else begin
        $error("phy_tx_done held longer than one cycle");
        fail_count++;
    end

    // credits can never exceed the FIFO depth
    credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= tx_frame_pkg::fifo_depth)
    else begin
        $error("generator credit count above FIFO depth");
        fail_count++;
    end

    // the baseband window still runs three cycles after the end pulse
    bb_end_inside: assert property (@(posedge clk) disable iff (!rstn)
        pulse_tx_bb_end |-> ##3 tx_bb_is_ongoing)
    else begin
        $error("baseband window ended too soon after pulse_tx_bb_end");
        fail_count++;
    end

endmodule

bind tx_top tx_top_properties u_props (
    .clk              (clk),
    .rstn             (rstn),
    .phy_tx_start     (phy_tx_start),
    .phy_tx_done      (phy_tx_done),
    .credit_cnt       (u_gen.credit_cnt),
    .pulse_tx_bb_end  (pulse_tx_bb_end),
    .tx_bb_is_ongoing (tx_bb_is_ongoing)
);
